// File: sources.f
+incdir+hw
hw/ex_pkg.sv
hw/mips_isa_pkg.sv
hw/alu_op_if.sv
hw/alu_control.sv
hw/alu.sv
hw/ex_handshake.sv
hw/ex_unit.sv
verif/ex_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ex_unit_tb -f sources.f \
  -o ex_unit_sim > sim.log 2>&1 \
  && ./obj_dir/ex_unit_sim >> sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: verif/ex_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_unit_tb;

  localparam int ACK_TIMEOUT = 20;
  localparam int HOLD_CYCLES = 3;
  localparam int N_RANDOM    = 40;

  // Opcode in the top six bits and funct in the low six
  localparam logic [11:0] RAND_OPS [12] = '{
    12'h020, 12'h022, 12'h024, 12'h027, 12'h02a, 12'h02b,
    12'h003, 12'h007, 12'h200, 12'h280, 12'h2c0, 12'h300
  };

  typedef struct packed {
    logic [5:0]  opc;
    logic [5:0]  fn;
    logic [4:0]  sh;
    logic [15:0] imm;
    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] res;
  } row_t;

  logic        clk;
  logic        rst;
  logic        i_req;
  logic [5:0]  i_opcode;
  logic [5:0]  i_funct;
  logic [4:0]  i_shamt;
  logic [15:0] i_imm;
  logic [31:0] i_rs_val;
  logic [31:0] i_rt_val;
  logic        o_ack;
  logic [31:0] o_result;

  row_t        rows[$];
  integer      seed;
  int          value_errors;
  int          timeouts;

  ex_unit dut0 (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_req    (i_req),
    .i_opcode (i_opcode),
    .i_funct  (i_funct),
    .i_shamt  (i_shamt),
    .i_imm    (i_imm),
    .i_rs_val (i_rs_val),
    .i_rt_val (i_rt_val),
    .o_ack    (o_ack),
    .o_result (o_result)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic add_row(input logic [5:0] opc, fn, input logic [4:0] sh,
                         input logic [15:0] imm, input logic [31:0] rs, rt, res);
    rows.push_back({opc, fn, sh, imm, rs, rt, res});
  endtask

  // Expected result straight from the instruction set rules
  task automatic model_result(input row_t r, output logic [31:0] res);
    logic [31:0] se;
    logic [31:0] ze;
    se  = {{16{r.imm[15]}}, r.imm};
    ze  = {16'h0000, r.imm};
    res = 32'h000000a1; // Unknown code
    if (r.opc == 6'h00) begin
      case (r.fn)
        6'h00: res = r.rt << r.sh;
        6'h02: res = r.rt >> r.sh;
        6'h03: res = $signed(r.rt) >>> r.sh;
        6'h04: res = r.rt << r.rs[4:0];
        6'h06: res = r.rt >> r.rs[4:0];
        6'h07: res = $signed(r.rt) >>> r.rs[4:0];
        6'h20, 6'h21: res = r.rs + r.rt;
        6'h22, 6'h23: res = r.rs - r.rt;
        6'h24: res = r.rs & r.rt;
        6'h25: res = r.rs | r.rt;
        6'h26: res = r.rs ^ r.rt;
        6'h27: res = ~(r.rs | r.rt);
        6'h2a: res = {31'd0, $signed(r.rs) < $signed(r.rt)};
        6'h2b: res = {31'd0, r.rs < r.rt};
        default: ;
      endcase
    end else begin
      case (r.opc)
        6'h08, 6'h09: res = r.rs + se;
        6'h0a: res = {31'd0, $signed(r.rs) < $signed(se)};
        6'h0b: res = {31'd0, r.rs < se};
        6'h0c: res = r.rs & ze;
        6'h0d: res = r.rs | ze;
        6'h0e: res = r.rs ^ ze;
        6'h0f: res = {r.imm, 16'h0000};
        default: ;
      endcase
    end
  endtask

  // One full four-phase transfer that can hold req past the ack
  task automatic run_row(input row_t r, input int idx, input bit hold);
    int          cycles;
    logic [31:0] rnd;
    i_opcode = r.opc;
    i_funct  = r.fn;
    i_shamt  = r.sh;
    i_imm    = r.imm;
    i_rs_val = r.rs;
    i_rt_val = r.rt;
    i_req    = 1'b1;
    cycles   = 0;
    while (!o_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_ack) begin
      $display("Timeout at %0t: o_ack never rose for row %0d", $time, idx);
      timeouts++;
    end else begin
      check_value("o_ack rise latency", 32'd2, cycles);
      check_value("o_result", r.res, o_result);
    end
    if (hold) begin
      for (int k = 0; k < HOLD_CYCLES; k++) begin
        rnd      = $random(seed);
        i_rs_val = rnd; // Fields may change once acked
        i_rt_val = ~rnd;
        i_opcode = rnd[5:0];
        @(negedge clk);
        check_value("o_ack", 32'd1, {31'd0, o_ack});
        check_value("o_result", r.res, o_result);
      end
    end
    i_req  = 1'b0;
    cycles = 0;
    while (o_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (o_ack) begin
      $display("Timeout at %0t: o_ack never fell for row %0d", $time, idx);
      timeouts++;
    end else begin
      check_value("o_ack fall latency", 32'd1, cycles);
    end
  endtask

  initial begin
    row_t        r;
    logic [31:0] rnd;
    logic [11:0] pick;
    seed         = 32'h5a7b;
    value_errors = 0;
    timeouts     = 0;
    clk      = 1'b0;
    rst      = 1'b1;
    i_req    = 1'b0;
    i_opcode = 6'h00;
    i_funct  = 6'h00;
    i_shamt  = 5'd0;
    i_imm    = 16'h0000;
    i_rs_val = 32'h0;
    i_rt_val = 32'h0;

    // R-type arithmetic and logic with wrap-around
    add_row(6'h00, 6'h20, 5'd0, 16'h0, 32'h5, 32'h7, 32'hc);
    add_row(6'h00, 6'h20, 5'd0, 16'h0, 32'h7fffffff, 32'h1, 32'h80000000);
    add_row(6'h00, 6'h21, 5'd0, 16'h0, 32'hffffffff, 32'h2, 32'h1);
    add_row(6'h00, 6'h22, 5'd0, 16'h0, 32'h5, 32'h7, 32'hfffffffe);
    add_row(6'h00, 6'h23, 5'd0, 16'h0, 32'h80000000, 32'h1, 32'h7fffffff);
    add_row(6'h00, 6'h24, 5'd0, 16'h0, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
    add_row(6'h00, 6'h25, 5'd0, 16'h0, 32'hf0f0f0f0, 32'h0f0f0000, 32'hfffff0f0);
    add_row(6'h00, 6'h26, 5'd0, 16'h0, 32'haaaa5555, 32'hffff0000, 32'h55555555);
    add_row(6'h00, 6'h27, 5'd0, 16'h0, 32'h0000ffff, 32'h00ff0000, 32'hff000000);
    // Compares and shifts
    add_row(6'h00, 6'h2a, 5'd0, 16'h0, 32'hffffffff, 32'h1, 32'h1);
    add_row(6'h00, 6'h2b, 5'd0, 16'h0, 32'hffffffff, 32'h1, 32'h0);
    add_row(6'h00, 6'h00, 5'd4, 16'h0, 32'h0, 32'h80000011, 32'h00000110);
    add_row(6'h00, 6'h02, 5'd4, 16'h0, 32'h0, 32'h80000010, 32'h08000001);
    add_row(6'h00, 6'h03, 5'd4, 16'h0, 32'h0, 32'h80000010, 32'hf8000001);
    add_row(6'h00, 6'h04, 5'd0, 16'h0, 32'h00000024, 32'h3, 32'h30);
    add_row(6'h00, 6'h06, 5'd0, 16'h0, 32'hffffffe8, 32'hf0000000, 32'h00f00000);
    add_row(6'h00, 6'h07, 5'd0, 16'h0, 32'h00000108, 32'h80000000, 32'hff800000);
    // I-type immediates
    add_row(6'h08, 6'h00, 5'd0, 16'hffff, 32'ha, 32'h0, 32'h9);
    add_row(6'h09, 6'h00, 5'd0, 16'h8000, 32'h0, 32'h0, 32'hffff8000);
    add_row(6'h0a, 6'h00, 5'd0, 16'hfffe, 32'hfffffffd, 32'h0, 32'h1);
    add_row(6'h0a, 6'h00, 5'd0, 16'hffff, 32'h5, 32'h0, 32'h0);
    add_row(6'h0b, 6'h00, 5'd0, 16'hffff, 32'h5, 32'h0, 32'h1);
    add_row(6'h0c, 6'h00, 5'd0, 16'h8f0f, 32'hffffffff, 32'h0, 32'h00008f0f);
    add_row(6'h0d, 6'h00, 5'd0, 16'h8000, 32'h12340000, 32'h0, 32'h12348000);
    add_row(6'h0e, 6'h00, 5'd0, 16'hffff, 32'hffff1234, 32'h0, 32'hffffedcb);
    add_row(6'h0f, 6'h00, 5'd0, 16'hbeef, 32'h12345678, 32'h0, 32'hbeef0000);
    // Unknown opcode and then unknown funct
    add_row(6'h23, 6'h00, 5'd0, 16'h1234, 32'h1, 32'h2, 32'h000000a1);
    add_row(6'h00, 6'h01, 5'd0, 16'h0, 32'h1, 32'h2, 32'h000000a1);

    for (int i = 0; i < N_RANDOM; i++) begin
      pick  = RAND_OPS[$unsigned($random(seed)) % 12];
      rnd   = $random(seed);
      r.opc = pick[11:6];
      r.fn  = pick[5:0];
      r.sh  = rnd[4:0];
      r.imm = rnd[31:16];
      r.rs  = $random(seed);
      r.rt  = $random(seed);
      model_result(r, r.res);
      rows.push_back(r);
    end

    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("o_ack", 32'd0, {31'd0, o_ack});
    check_value("o_result", 32'd0, o_result);

    foreach (rows[i]) begin
      run_row(rows[i], i, (i % 7) == 3);
    end

    $display("Rows applied: %0d, value errors: %0d, timeouts: %0d",
             rows.size(), value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/ex_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_unit (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_req,
  input  logic [`EX_NB_OP-1:0]    i_opcode,
  input  logic [`EX_NB_OP-1:0]    i_funct,
  input  logic [`EX_NB_SHAMT-1:0] i_shamt,
  input  logic [`EX_NB_IMM-1:0]   i_imm,
  input  logic [`EX_NB_DATA-1:0]  i_rs_val,
  input  logic [`EX_NB_DATA-1:0]  i_rt_val,
  output logic                    o_ack,
  output logic [`EX_NB_DATA-1:0]  o_result
);
  import mips_isa_pkg::*;

  // Registered request fields
  opcode_e                 opcode_r;
  funct_e                  funct_r;
  logic [`EX_NB_SHAMT-1:0] shamt_r;
  logic [`EX_NB_IMM-1:0]   imm_r;
  logic [`EX_NB_DATA-1:0]  rs_val_r;
  logic [`EX_NB_DATA-1:0]  rt_val_r;
  logic [`EX_NB_DATA-1:0]  alu_result;

  alu_op_if alu_bus ();

  ex_handshake hs0 (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req        (i_req),
    .i_opcode     (i_opcode),
    .i_funct      (i_funct),
    .i_shamt      (i_shamt),
    .i_imm        (i_imm),
    .i_rs_val     (i_rs_val),
    .i_rt_val     (i_rt_val),
    .i_alu_result (alu_result),
    .o_opcode     (opcode_r),
    .o_funct      (funct_r),
    .o_shamt      (shamt_r),
    .o_imm        (imm_r),
    .o_rs_val     (rs_val_r),
    .o_rt_val     (rt_val_r),
    .o_ack        (o_ack),
    .o_result     (o_result)
  );

  alu_control ctl0 (
    .i_opcode (opcode_r),
    .i_funct  (funct_r),
    .i_shamt  (shamt_r),
    .i_imm    (imm_r),
    .i_rs_val (rs_val_r),
    .i_rt_val (rt_val_r),
    .alu_bus  (alu_bus.decoder)
  );

  alu alu0 (
    .alu_bus  (alu_bus.alu),
    .o_result (alu_result)
  );

endmodule

`default_nettype wire

// File: hw/ex_handshake.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_handshake (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_req,
  input  logic [`EX_NB_OP-1:0]    i_opcode,
  input  logic [`EX_NB_OP-1:0]    i_funct,
  input  logic [`EX_NB_SHAMT-1:0] i_shamt,
  input  logic [`EX_NB_IMM-1:0]   i_imm,
  input  logic [`EX_NB_DATA-1:0]  i_rs_val,
  input  logic [`EX_NB_DATA-1:0]  i_rt_val,
  input  logic [`EX_NB_DATA-1:0]  i_alu_result,
  output mips_isa_pkg::opcode_e   o_opcode,
  output mips_isa_pkg::funct_e    o_funct,
  output logic [`EX_NB_SHAMT-1:0] o_shamt,
  output logic [`EX_NB_IMM-1:0]   o_imm,
  output logic [`EX_NB_DATA-1:0]  o_rs_val,
  output logic [`EX_NB_DATA-1:0]  o_rt_val,
  output logic                    o_ack,
  output logic [`EX_NB_DATA-1:0]  o_result
);
  import mips_isa_pkg::*;
  import ex_pkg::*;

  hs_state_e state;
  logic      accept;

  assign accept = (state == IDLE) && i_req;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= IDLE;
      o_result <= '0;
    end else begin
      case (state)
        IDLE: if (i_req) state <= CALC;
        CALC: begin
          o_result <= i_alu_result; // ALU has settled on the held fields
          state    <= ACK;
        end
        ACK: if (!i_req) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Fields held so upstream may change them once acked
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_opcode <= opcode_e'(i_opcode);
      o_funct  <= funct_e'(i_funct);
      o_shamt  <= i_shamt;
      o_imm    <= i_imm;
      o_rs_val <= i_rs_val;
      o_rt_val <= i_rt_val;
    end
  end

  assign o_ack = (state == ACK);

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module alu (
  alu_op_if.alu                  alu_bus,
  output logic [`EX_NB_DATA-1:0] o_result
);
  import ex_pkg::*;

  logic        [`EX_NB_DATA-1:0]  a;
  logic        [`EX_NB_DATA-1:0]  b;
  logic signed [`EX_NB_DATA-1:0]  a_s;
  logic signed [`EX_NB_DATA-1:0]  b_s;
  logic        [`EX_NB_SHAMT-1:0] var_sh;
  logic                           lt_s;
  logic                           lt_u;

  assign a   = alu_bus.data_a;
  assign b   = alu_bus.data_b;
  assign a_s = alu_bus.data_a;
  assign b_s = alu_bus.data_b;

  // Variable shifts only look at the low bits of A
  assign var_sh = a[`EX_NB_SHAMT-1:0];

  assign lt_s = (a_s < b_s);
  assign lt_u = (a < b);

  always_comb begin
    case (alu_bus.op)
      // Both flavours wrap since there is no overflow trap
      ALU_ADD, ALU_ADDU: o_result = a + b;
      ALU_SUB, ALU_SUBU: o_result = a - b;

      ALU_AND: o_result = a & b;
      ALU_OR:  o_result = a | b;
      ALU_XOR: o_result = a ^ b;
      ALU_NOR: o_result = ~(a | b);

      ALU_SLT:  o_result = {{(`EX_NB_DATA-1){1'b0}}, lt_s};
      ALU_SLTU: o_result = {{(`EX_NB_DATA-1){1'b0}}, lt_u};

      ALU_SLL: o_result = b << alu_bus.shamt;
      ALU_SRL: o_result = b >> alu_bus.shamt;
      ALU_SRA: o_result = b_s >>> alu_bus.shamt; // Sign fill

      ALU_SLLV: o_result = b << var_sh;
      ALU_SRLV: o_result = b >> var_sh;
      ALU_SRAV: o_result = b_s >>> var_sh;

      ALU_LUI: o_result = b << `EX_LUI_SHIFT;

      default: o_result = {{(`EX_NB_DATA-8){1'b0}}, `EX_ILLEGAL_MARK};
    endcase
  end

endmodule

`default_nettype wire

// File: hw/alu_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module alu_control (
  input  mips_isa_pkg::opcode_e   i_opcode,
  input  mips_isa_pkg::funct_e    i_funct,
  input  logic [`EX_NB_SHAMT-1:0] i_shamt,
  input  logic [`EX_NB_IMM-1:0]   i_imm,
  input  logic [`EX_NB_DATA-1:0]  i_rs_val,
  input  logic [`EX_NB_DATA-1:0]  i_rt_val,
  alu_op_if.decoder               alu_bus
);
  import mips_isa_pkg::*;
  import ex_pkg::*;

  logic [`EX_NB_DATA-1:0] imm_sext;
  logic [`EX_NB_DATA-1:0] imm_zext;
  logic                   zero_ext;

  assign imm_sext = {{(`EX_NB_DATA-`EX_NB_IMM){i_imm[`EX_NB_IMM-1]}}, i_imm};
  assign imm_zext = {{(`EX_NB_DATA-`EX_NB_IMM){1'b0}}, i_imm};

  // Logical immediates are zero-extended
  assign zero_ext = (i_opcode == OP_ANDI) || (i_opcode == OP_ORI) || (i_opcode == OP_XORI);

  always_comb begin
    case (i_opcode)
      OP_SPECIAL: begin
        case (i_funct)
          FN_ADD:  alu_bus.op = ALU_ADD;
          FN_ADDU: alu_bus.op = ALU_ADDU;
          FN_SUB:  alu_bus.op = ALU_SUB;
          FN_SUBU: alu_bus.op = ALU_SUBU;
          FN_AND:  alu_bus.op = ALU_AND;
          FN_OR:   alu_bus.op = ALU_OR;
          FN_XOR:  alu_bus.op = ALU_XOR;
          FN_NOR:  alu_bus.op = ALU_NOR;
          FN_SLT:  alu_bus.op = ALU_SLT;
          FN_SLTU: alu_bus.op = ALU_SLTU;
          FN_SLL:  alu_bus.op = ALU_SLL;
          FN_SRL:  alu_bus.op = ALU_SRL;
          FN_SRA:  alu_bus.op = ALU_SRA;
          FN_SLLV: alu_bus.op = ALU_SLLV;
          FN_SRLV: alu_bus.op = ALU_SRLV;
          FN_SRAV: alu_bus.op = ALU_SRAV;
          default: alu_bus.op = ALU_ILLEGAL; // Unknown funct
        endcase
      end
      OP_ADDI:  alu_bus.op = ALU_ADD;
      OP_ADDIU: alu_bus.op = ALU_ADDU;
      OP_SLTI:  alu_bus.op = ALU_SLT;
      OP_SLTIU: alu_bus.op = ALU_SLTU;
      OP_ANDI:  alu_bus.op = ALU_AND;
      OP_ORI:   alu_bus.op = ALU_OR;
      OP_XORI:  alu_bus.op = ALU_XOR;
      OP_LUI:   alu_bus.op = ALU_LUI;
      default:  alu_bus.op = ALU_ILLEGAL;
    endcase
  end

  assign alu_bus.data_a = i_rs_val;
  assign alu_bus.shamt  = i_shamt;

  // Operand B is rt for R-type and the extended immediate otherwise
  assign alu_bus.data_b = (i_opcode == OP_SPECIAL) ? i_rt_val :
                          zero_ext                 ? imm_zext : imm_sext;

endmodule

`default_nettype wire

// File: hw/alu_op_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

interface alu_op_if;
  import ex_pkg::*;

  alu_op_e                 op;
  logic [`EX_NB_DATA-1:0]  data_a;
  logic [`EX_NB_DATA-1:0]  data_b;
  logic [`EX_NB_SHAMT-1:0] shamt; // Fixed shift amount from the instruction

  modport decoder (
    output op, data_a, data_b, shamt
  );

  modport alu (
    input op, data_a, data_b, shamt
  );

endinterface

`default_nettype wire

// File: hw/mips_isa_pkg.sv
`default_nettype none

`include "ex_consts.svh"

package mips_isa_pkg;

  // Primary opcode field
  typedef enum logic [`EX_NB_OP-1:0] {
    OP_SPECIAL = 6'b000000, // R-type with the operation in funct
    OP_ADDI    = 6'b001000,
    OP_ADDIU   = 6'b001001,
    OP_SLTI    = 6'b001010,
    OP_SLTIU   = 6'b001011,
    OP_ANDI    = 6'b001100,
    OP_ORI     = 6'b001101,
    OP_XORI    = 6'b001110,
    OP_LUI     = 6'b001111
  } opcode_e;

  // R-type funct field
  typedef enum logic [`EX_NB_OP-1:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100,
    FN_SRLV = 6'b000110,
    FN_SRAV = 6'b000111,
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_e;

endpackage

`default_nettype wire

// File: hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

  // Operations the ALU understands
  typedef enum logic [4:0] {
    ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLLV, ALU_SRLV, ALU_SRAV,
    ALU_LUI,
    ALU_ILLEGAL
  } alu_op_e;

  // Four-phase handshake states
  typedef enum logic [1:0] {
    IDLE = 2'd0, // Waiting for a request
    CALC = 2'd1, // Fields held while the ALU settles
    ACK  = 2'd2  // Result out until req drops
  } hs_state_e;

endpackage

`default_nettype wire

// File: hw/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath width
`define EX_NB_DATA 32

// Instruction field widths
`define EX_NB_OP    6
`define EX_NB_SHAMT 5
`define EX_NB_IMM   16

`define EX_LUI_SHIFT 16 // Immediate goes to the upper half

// Low byte returned for an unknown opcode or funct
`define EX_ILLEGAL_MARK 8'ha1

`endif
